// ==== flist.f ====
src/video_pkg.sv
src/host_regs.sv
src/raster_timing.sv
src/crtc_address.sv
src/ula_pixel.sv
src/display_control.sv
verif/tb_display_control.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_display_control
RTL_TOP   ?= display_control
FLIST     ?= flist.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)

// ==== verif/tb_display_control.sv ====
`default_nettype none

module tb_display_control;

	// Small raster so one frame is 1500 clocks
	localparam int H_DISPLAY = 20;
	localparam int H_FRONT   = 2;
	localparam int H_PULSE   = 4;
	localparam int H_BACK    = 4;
	localparam int V_DISPLAY = 40;
	localparam int V_FRONT   = 2;
	localparam int V_PULSE   = 3;
	localparam int V_BACK    = 5;
	localparam int HT        = H_DISPLAY + H_FRONT + H_PULSE + H_BACK;
	localparam int VT        = V_DISPLAY + V_FRONT + V_PULSE + V_BACK;
	localparam int TIMEOUT   = 4 * HT * VT * 5;
	localparam logic [7:0] HD      = 8'd16;
	localparam logic [6:0] VD      = 7'd8;
	localparam logic [4:0] MAX_ROW = 5'd3;

	logic                 PIXELCLK;
	logic                 nRESET;
	video_pkg::host_bus_t bus;
	logic [7:0]           rdata;
	logic                 ram_en;
	logic                 proc_en;
	logic                 half_en;
	logic                 dram_en;
	logic [7:0]           vdata;
	logic                 vga_hs;
	logic                 vga_vs;
	logic                 red;
	logic                 green;
	logic                 blue;
	logic [13:0]          framestore_adr;
	logic [4:0]           row_address;

	logic [31:0] lfsr;
	logic [3:0]  pal [16];
	logic        flash;
	logic [13:0] start_adr;
	int          cycles;

	display_control #(
		.H_DISPLAY (H_DISPLAY), .H_FRONT (H_FRONT), .H_PULSE (H_PULSE), .H_BACK (H_BACK),
		.V_DISPLAY (V_DISPLAY), .V_FRONT (V_FRONT), .V_PULSE (V_PULSE), .V_BACK (V_BACK)
	) u_display_control (
		.PIXELCLK (PIXELCLK), .nRESET (nRESET), .bus (bus), .rdata (rdata),
		.ram_en (ram_en), .proc_en (proc_en), .half_en (half_en), .dram_en (dram_en),
		.vdata (vdata), .vga_hs (vga_hs), .vga_vs (vga_vs),
		.red (red), .green (green), .blue (blue),
		.framestore_adr (framestore_adr), .row_address (row_address)
	);

	initial begin
		PIXELCLK = 1'b0;
		forever #5 PIXELCLK = ~PIXELCLK;
	end

	always @(posedge PIXELCLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d clocks", TIMEOUT);
			$display("TB FAILED");
			$fatal(1, "simulation hung");
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	// Palette lookup, flash hold, blanking and cursor inversion
	function automatic logic [2:0] expected_rgb(input logic [7:0] data, input logic active,
		input logic inverted);
		logic [3:0] phys;
		logic [2:0] shade;
		phys = pal[{data[7], data[5], data[3], data[1]}];
		if (!active)
			shade = 3'b000;
		else if (flash && phys[3])
			shade = phys[2:0];
		else
			shade = ~phys[2:0];
		expected_rgb = inverted ? ~shade : shade;
	endfunction

	task automatic report_value(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		if (got !== exp)
			report_value($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_adr(input logic [13:0] got, input logic [13:0] exp, input string what);
		if (got !== exp)
			report_value($sformatf("%s got %h expected %h", what, got, exp));
	endtask

	task automatic check_row(input logic [4:0] got, input logic [4:0] exp, input string what);
		if (got !== exp)
			report_value($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic check_colour(input logic [2:0] got, input logic [2:0] exp, input string what);
		if (got !== exp)
			report_value($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			report_value($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	task automatic bus_write(input logic to_crtc, input logic a0, input logic [7:0] data);
		video_pkg::host_bus_t b;
		b = '0;
		b.cs_crtc = to_crtc;
		b.cs_ula = !to_crtc;
		b.a0 = a0;
		b.strobe = 1'b1;
		b.wdata = data;
		@(posedge PIXELCLK);
		bus <= b;
		@(posedge PIXELCLK);
		bus <= '0;
	endtask

	task automatic crtc_write(input logic [4:0] num, input logic [7:0] data);
		bus_write(1'b1, 1'b0, {3'b000, num});
		bus_write(1'b1, 1'b1, data);
	endtask

	task automatic crtc_read(input logic [4:0] num, output logic [7:0] data);
		video_pkg::host_bus_t b;
		bus_write(1'b1, 1'b0, {3'b000, num});
		b = '0;
		b.cs_crtc = 1'b1;
		b.rnw = 1'b1;
		b.strobe = 1'b1;
		@(posedge PIXELCLK);
		bus <= b;
		@(negedge PIXELCLK);
		data = rdata;
		@(posedge PIXELCLK);
		bus <= '0;
	endtask

	// Returns on the first clock of the back porch
	task automatic wait_vsync_end();
		while (!vga_vs)
			@(negedge PIXELCLK);
		while (vga_vs)
			@(negedge PIXELCLK);
	endtask

	// One display frame, cursor_row below zero means no cursor
	task automatic check_frame(input int cursor_row);
		int row;
		logic active;
		logic inv;
		logic [13:0] row_start;
		wait_vsync_end();
		repeat (V_BACK * HT) @(negedge PIXELCLK);
		for (int l = 0; l < V_DISPLAY; l++) begin
			row = l / (MAX_ROW + 1);
			row_start = start_adr + 14'(row * HD);
			for (int c = 0; c < HT; c++) begin
				if (c == 0) begin
					check_adr(framestore_adr, row_start, "line start address");
					check_row(row_address, 5'(l % (MAX_ROW + 1)), "row address");
				end
				active = row < VD && c >= 1 && c <= HD;
				inv = row == cursor_row && c == 1;
				check_colour({blue, green, red}, expected_rgb(vdata, active, inv), "pixel colour");
				@(negedge PIXELCLK);
			end
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [7:0]  hi;
		logic [7:0]  lo;
		logic [7:0]  got;
		int          n;
		lfsr = 32'hea45_326d;
		cycles = 0;
		nRESET <= 1'b0;
		bus <= '0;
		ram_en <= 1'b1;
		proc_en <= 1'b0;
		half_en <= 1'b0;
		dram_en <= 1'b0;
		vdata <= 8'h00;
		repeat (7) @(posedge PIXELCLK);
		@(negedge PIXELCLK);
		check_colour({blue, green, red}, 3'b000, "colour in reset");
		check_adr(framestore_adr, 14'h0, "address in reset");
		check_count({vga_hs, vga_vs}, 0, "syncs in reset");
		@(posedge PIXELCLK);
		nRESET <= 1'b1;

		// Fast clock mode runs the CRTC from the free RAM slots
		bus_write(1'b0, 1'b0, 8'h10);

		// Cursor address readback
		random_bits(8, r);
		hi = r[7:0];
		random_bits(8, r);
		lo = r[7:0];
		crtc_write(5'd14, hi);
		crtc_write(5'd15, lo);
		crtc_read(5'd14, got);
		check_byte(got, {2'b00, hi[5:0]}, "cursor address high");
		crtc_read(5'd15, got);
		check_byte(got, lo, "cursor address low");

		// Sync widths and line period
		while (!vga_hs)
			@(negedge PIXELCLK);
		n = 0;
		while (vga_hs) begin
			n++;
			@(negedge PIXELCLK);
		end
		check_count(n, H_PULSE, "hsync width");
		while (!vga_hs) begin
			n++;
			@(negedge PIXELCLK);
		end
		check_count(n, HT, "line period");
		while (!vga_vs)
			@(negedge PIXELCLK);
		n = 0;
		while (vga_vs) begin
			n++;
			@(negedge PIXELCLK);
		end
		check_count(n % HT, 0, "vsync edge offset");
		check_count(n / HT, V_PULSE, "vsync lines");

		// Display geometry, fast clock and palette
		random_bits(14, r);
		start_adr = r[13:0];
		crtc_write(5'd1, HD);
		crtc_write(5'd6, {1'b0, VD});
		crtc_write(5'd8, 8'h00);
		crtc_write(5'd9, {3'b000, MAX_ROW});
		crtc_write(5'd12, {2'b00, start_adr[13:8]});
		crtc_write(5'd13, start_adr[7:0]);
		crtc_write(5'd10, 8'h20);
		crtc_write(5'd11, {3'b000, MAX_ROW});
		random_bits(1, r);
		flash = r[0];
		bus_write(1'b0, 1'b0, {4'b0001, 3'b000, flash});
		for (int i = 0; i < 16; i++) begin
			random_bits(4, r);
			pal[i] = r[3:0];
			bus_write(1'b0, 1'b1, {4'(i), pal[i]});
		end
		random_bits(8, r);
		@(posedge PIXELCLK);
		vdata <= r[7:0];
		check_frame(-1);

		// Steady cursor on the third character row
		crtc_write(5'd14, {2'b00, 6'((start_adr + 14'(2 * HD)) >> 8)});
		crtc_write(5'd15, 8'(start_adr + 14'(2 * HD)));
		crtc_write(5'd10, 8'h00);
		bus_write(1'b0, 1'b0, {4'b1001, 3'b000, flash});
		check_frame(2);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/display_control.sv ====
`default_nettype none

module display_control #(
	parameter int H_DISPLAY = video_pkg::H_DISPLAY,
	parameter int H_FRONT   = video_pkg::H_FRONT,
	parameter int H_PULSE   = video_pkg::H_PULSE,
	parameter int H_BACK    = video_pkg::H_BACK,
	parameter int V_DISPLAY = video_pkg::V_DISPLAY,
	parameter int V_FRONT   = video_pkg::V_FRONT,
	parameter int V_PULSE   = video_pkg::V_PULSE,
	parameter int V_BACK    = video_pkg::V_BACK
) (
	input  wire                    PIXELCLK,
	input  wire                    nRESET,
	input  wire video_pkg::host_bus_t bus,
	output logic [7:0]             rdata,
	input  wire                    ram_en,
	input  wire                    proc_en,
	input  wire                    half_en,
	input  wire                    dram_en,
	input  wire [7:0]              vdata,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   red,
	output logic                   green,
	output logic                   blue,
	output logic [13:0]            framestore_adr,
	output logic [4:0]             row_address
);

	video_pkg::crtc_regs_t    crtc;
	video_pkg::ula_control_t  control;
	video_pkg::raster_marks_t marks;
	logic [15:0][3:0]         palette;
	logic                     crtc_en;
	logic                     disen;
	logic                     cursor_hit;

	// Fast mode takes the RAM slots the processor leaves free
	assign crtc_en = control.fast_clock ? (ram_en && !proc_en) : half_en;

	host_regs u_host_regs (
		.PIXELCLK (PIXELCLK),
		.nRESET   (nRESET),
		.bus      (bus),
		.rdata    (rdata),
		.crtc     (crtc),
		.control  (control),
		.palette  (palette)
	);

	raster_timing #(
		.H_DISPLAY (H_DISPLAY),
		.H_FRONT   (H_FRONT),
		.H_PULSE   (H_PULSE),
		.H_BACK    (H_BACK),
		.V_DISPLAY (V_DISPLAY),
		.V_FRONT   (V_FRONT),
		.V_PULSE   (V_PULSE),
		.V_BACK    (V_BACK)
	) u_raster_timing (
		.PIXELCLK (PIXELCLK),
		.nRESET   (nRESET),
		.crtc_en  (crtc_en),
		.hsync    (vga_hs),
		.vsync    (vga_vs),
		.marks    (marks)
	);

	crtc_address u_crtc_address (
		.PIXELCLK       (PIXELCLK),
		.nRESET         (nRESET),
		.crtc_en        (crtc_en),
		.marks          (marks),
		.crtc           (crtc),
		.framestore_adr (framestore_adr),
		.row_address    (row_address),
		.disen          (disen),
		.cursor_hit     (cursor_hit)
	);

	ula_pixel u_ula_pixel (
		.PIXELCLK   (PIXELCLK),
		.nRESET     (nRESET),
		.crtc_en    (crtc_en),
		.proc_en    (proc_en),
		.ram_en     (ram_en),
		.dram_en    (dram_en),
		.vdata      (vdata),
		.control    (control),
		.palette    (palette),
		.disen      (disen),
		.row3       (row_address[3]),
		.cursor_hit (cursor_hit),
		.red        (red),
		.green      (green),
		.blue       (blue)
	);

endmodule

`default_nettype wire

// ==== src/ula_pixel.sv ====
`default_nettype none

module ula_pixel (
	input  wire                      PIXELCLK,
	input  wire                      nRESET,
	input  wire                      crtc_en,
	input  wire                      proc_en,
	input  wire                      ram_en,
	input  wire                      dram_en,
	input  wire [7:0]                vdata,
	input  wire video_pkg::ula_control_t control,
	input  wire [15:0][3:0]          palette,
	input  wire                      disen,
	input  wire                      row3,
	input  wire                      cursor_hit,
	output logic                     red,
	output logic                     green,
	output logic                     blue
);

	logic [7:0] shifter;
	logic       shift_en;
	logic [2:0] cursor_seg;
	logic       cursor_draw;
	logic [3:0] colour;
	logic       flash_hold;
	logic [2:0] pixel;

	always_comb begin
		case (control.shift_rate)
			2'b00: shift_en = proc_en;
			2'b01: shift_en = ram_en;
			2'b10: shift_en = dram_en;
			2'b11: shift_en = 1'b1;
		endcase
	end

	// Ones shift in so an emptied byte reads as logical colour 15
	always_ff @(posedge PIXELCLK) begin
		if (crtc_en)
			shifter <= vdata;
		else if (shift_en)
			shifter <= {shifter[6:0], 1'b1};
	end

	// History of cursor characters, one bit per character already drawn
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			cursor_seg <= '0;
		end else if (crtc_en) begin
			cursor_seg <= {cursor_seg[1:0], cursor_hit};
		end
	end

	assign cursor_draw = (cursor_hit && control.cursor_seg0)
		|| (cursor_seg[0] && control.cursor_seg1)
		|| (cursor_seg[1] && control.cursor_seg23)
		|| (cursor_seg[2] && control.cursor_seg23);

	assign colour = palette[{shifter[7], shifter[5], shifter[3], shifter[1]}];

	// Flashing colours show true while flash is set
	assign flash_hold = colour[3] && control.flash;
	assign pixel = (disen && !row3) ? (flash_hold ? colour[2:0] : ~colour[2:0]) : 3'b000;

	assign {blue, green, red} = cursor_draw ? ~pixel : pixel;

endmodule

`default_nettype wire

// ==== src/crtc_address.sv ====
`default_nettype none

module crtc_address (
	input  wire                      PIXELCLK,
	input  wire                      nRESET,
	input  wire                      crtc_en,
	input  wire video_pkg::raster_marks_t marks,
	input  wire video_pkg::crtc_regs_t    crtc,
	output logic [13:0]              framestore_adr,
	output logic [4:0]               row_address,
	output logic                     disen,
	output logic                     cursor_hit
);

	logic [7:0]  h_left;
	logic [6:0]  v_left;
	logic [13:0] line_start;
	logic        field;
	logic        interlace_sync;
	logic        new_vchar;
	logic        addr_active;
	logic        row_match;
	logic [6:0]  blink_count;
	logic        cursor_on;

	// Interlace sync only, rows are repeated over two progressive lines
	assign interlace_sync = crtc.interlace_mode == 2'b01;
	assign new_vchar = marks.new_line && row_address >= crtc.max_scanline
		&& (!interlace_sync || field);

	// Address points at a character inside the programmed window
	assign addr_active = marks.host_disen && h_left != '0 && v_left != '0;
	assign row_match = row_address >= crtc.cursor_start_row
		&& row_address <= crtc.cursor_end_row;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			h_left <= '0;
			v_left <= '0;
		end else if (crtc_en) begin
			if (marks.new_line)
				h_left <= crtc.horz_display;
			else if (h_left != '0)
				h_left <= h_left - 1'b1;

			if (marks.new_screen)
				v_left <= crtc.vert_display;
			else if (new_vchar && v_left != '0)
				v_left <= v_left - 1'b1;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			framestore_adr <= '0;
			line_start     <= '0;
		end else if (crtc_en) begin
			if (marks.new_screen) begin
				framestore_adr <= crtc.start_adr;
				line_start     <= crtc.start_adr;
			end else if (new_vchar) begin
				framestore_adr <= line_start + 14'(crtc.horz_display);
				line_start     <= line_start + 14'(crtc.horz_display);
			end else if (marks.new_line) begin
				framestore_adr <= line_start;
			end else begin
				framestore_adr <= framestore_adr + 1'b1;
			end
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			row_address <= '0;
			field       <= 1'b0;
		end else if (crtc_en) begin
			if (new_vchar || marks.new_screen) begin
				row_address <= '0;
				field       <= 1'b0;
			end else if (marks.new_line) begin
				field <= !field;
				if (!interlace_sync || field)
					row_address <= row_address + 1'b1;
			end
		end
	end

	// Blink phase sampled once per frame
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			blink_count <= '0;
			cursor_on   <= 1'b0;
		end else if (crtc_en && marks.new_screen) begin
			blink_count <= blink_count + 1'b1;
			case (crtc.cursor_blink_mode)
				2'b00: cursor_on <= 1'b1;
				2'b01: cursor_on <= 1'b0;
				2'b10: cursor_on <= blink_count[5];
				2'b11: cursor_on <= blink_count[6];
			endcase
		end
	end

	// Registered to line up with the byte in the ULA shifter
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			disen      <= 1'b0;
			cursor_hit <= 1'b0;
		end else if (crtc_en) begin
			disen      <= addr_active;
			cursor_hit <= addr_active && cursor_on && row_match
				&& framestore_adr == crtc.cursor_adr;
		end
	end

	a_row_limit: assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		(!interlace_sync && row_address <= crtc.max_scanline)
		|=> $changed(crtc.max_scanline) || $changed(crtc.interlace_mode)
		|| row_address <= crtc.max_scanline)
		else $error("Row address passed max_scanline");

endmodule

`default_nettype wire

// ==== src/raster_timing.sv ====
`default_nettype none

module raster_timing #(
	parameter int H_DISPLAY = video_pkg::H_DISPLAY,
	parameter int H_FRONT   = video_pkg::H_FRONT,
	parameter int H_PULSE   = video_pkg::H_PULSE,
	parameter int H_BACK    = video_pkg::H_BACK,
	parameter int V_DISPLAY = video_pkg::V_DISPLAY,
	parameter int V_FRONT   = video_pkg::V_FRONT,
	parameter int V_PULSE   = video_pkg::V_PULSE,
	parameter int V_BACK    = video_pkg::V_BACK
) (
	input  wire                      PIXELCLK,
	input  wire                      nRESET,
	input  wire                      crtc_en,
	output logic                     hsync,
	output logic                     vsync,
	output video_pkg::raster_marks_t marks
);

	localparam int HCW = $clog2(H_DISPLAY + H_FRONT + H_PULSE + H_BACK);
	localparam int VCW = $clog2(V_DISPLAY + V_FRONT + V_PULSE + V_BACK);

	video_pkg::raster_state_e h_state;
	video_pkg::raster_state_e v_state;
	logic [HCW-1:0]           h_count;
	logic [VCW-1:0]           v_count;
	logic                     h_last;
	logic                     v_last;

	function automatic video_pkg::raster_state_e next_state(video_pkg::raster_state_e st);
		next_state = video_pkg::raster_state_e'(st + 2'd1);
	endfunction

	// Count to load when leaving a phase, the length of the next one less one
	function automatic logic [HCW-1:0] h_reload(video_pkg::raster_state_e st);
		case (st)
			video_pkg::ST_DISPLAY: h_reload = HCW'(H_FRONT - 1);
			video_pkg::ST_FRONT:   h_reload = HCW'(H_PULSE - 1);
			video_pkg::ST_PULSE:   h_reload = HCW'(H_BACK - 1);
			default:               h_reload = HCW'(H_DISPLAY - 1);
		endcase
	endfunction

	function automatic logic [VCW-1:0] v_reload(video_pkg::raster_state_e st);
		case (st)
			video_pkg::ST_DISPLAY: v_reload = VCW'(V_FRONT - 1);
			video_pkg::ST_FRONT:   v_reload = VCW'(V_PULSE - 1);
			video_pkg::ST_PULSE:   v_reload = VCW'(V_BACK - 1);
			default:               v_reload = VCW'(V_DISPLAY - 1);
		endcase
	endfunction

	assign h_last = h_count == '0;
	assign v_last = v_count == '0;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			h_state <= video_pkg::ST_DISPLAY;
			h_count <= HCW'(H_DISPLAY - 1);
		end else if (crtc_en) begin
			if (h_last) begin
				h_state <= next_state(h_state);
				h_count <= h_reload(h_state);
			end else begin
				h_count <= h_count - 1'b1;
			end
		end
	end

	// Vertical axis steps once per line
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			v_state <= video_pkg::ST_DISPLAY;
			v_count <= VCW'(V_DISPLAY - 1);
		end else if (crtc_en && marks.new_line) begin
			if (v_last) begin
				v_state <= next_state(v_state);
				v_count <= v_reload(v_state);
			end else begin
				v_count <= v_count - 1'b1;
			end
		end
	end

	always_comb begin
		marks.new_line   = h_state == video_pkg::ST_BACK && h_last;
		marks.new_screen = marks.new_line && v_state == video_pkg::ST_BACK && v_last;
		marks.host_disen = h_state == video_pkg::ST_DISPLAY && v_state == video_pkg::ST_DISPLAY;
	end

	assign hsync = h_state == video_pkg::ST_PULSE;
	assign vsync = v_state == video_pkg::ST_PULSE;

	// Display counts stay below the display length
	a_state_legal: assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		!$isunknown({h_state, v_state})
		&& (h_state != video_pkg::ST_DISPLAY || int'(h_count) < H_DISPLAY)
		&& (v_state != video_pkg::ST_DISPLAY || int'(v_count) < V_DISPLAY))
		else $error("Raster state or count out of range");

endmodule

`default_nettype wire

// ==== src/host_regs.sv ====
`default_nettype none

module host_regs (
	input  wire                    PIXELCLK,
	input  wire                    nRESET,
	input  wire video_pkg::host_bus_t bus,
	output logic [7:0]             rdata,
	output video_pkg::crtc_regs_t  crtc,
	output video_pkg::ula_control_t control,
	output logic [15:0][3:0]       palette
);

	logic [4:0]            reg_sel;
	logic                  crtc_wr;
	logic                  ula_wr;
	video_pkg::ula_write_u ula_word;

	assign crtc_wr  = bus.strobe && !bus.rnw && bus.cs_crtc;
	assign ula_wr   = bus.strobe && !bus.rnw && bus.cs_ula;
	assign ula_word = bus.wdata;

	// Address register on a0 low, data register on a0 high
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			reg_sel <= '0;
			crtc    <= '0;
		end else if (crtc_wr) begin
			if (!bus.a0) begin
				reg_sel <= bus.wdata[4:0];
			end else begin
				case (reg_sel)
					5'd1:  crtc.horz_display   <= bus.wdata;
					5'd6:  crtc.vert_display   <= bus.wdata[6:0];
					5'd8:  crtc.interlace_mode <= bus.wdata[1:0];
					5'd9:  crtc.max_scanline   <= bus.wdata[4:0];
					5'd10: begin
						crtc.cursor_blink_mode <= bus.wdata[6:5];
						crtc.cursor_start_row  <= bus.wdata[4:0];
					end
					5'd11: crtc.cursor_end_row    <= bus.wdata[4:0];
					5'd12: crtc.start_adr[13:8]   <= bus.wdata[5:0];
					5'd13: crtc.start_adr[7:0]    <= bus.wdata;
					5'd14: crtc.cursor_adr[13:8]  <= bus.wdata[5:0];
					5'd15: crtc.cursor_adr[7:0]   <= bus.wdata;
					// Other 6845 registers are not implemented
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			control <= '0;
		end else if (ula_wr && !bus.a0) begin
			control <= ula_word.control;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (ula_wr && bus.a0) begin
			palette[ula_word.palette.index] <= ula_word.palette.colour;
		end
	end

	// Only the cursor address is readable
	always_comb begin
		rdata = 8'h00;
		if (bus.cs_crtc && bus.rnw && bus.strobe) begin
			rdata = reg_sel[0] ? crtc.cursor_adr[7:0] : {2'b00, crtc.cursor_adr[13:8]};
		end
	end

	a_single_cs: assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		bus.strobe |-> !(bus.cs_crtc && bus.cs_ula))
		else $error("CRTC and ULA selected together");

endmodule

`default_nettype wire

// ==== src/video_pkg.sv ====
`default_nettype none

package video_pkg;

	// 640x480 VGA with 8-pixel characters across and scan lines down
	localparam int H_DISPLAY = 80;
	localparam int H_FRONT   = 2;
	localparam int H_PULSE   = 12;
	localparam int H_BACK    = 6;
	localparam int V_DISPLAY = 480;
	localparam int V_FRONT   = 10;
	localparam int V_PULSE   = 2;
	localparam int V_BACK    = 33;

	// Phases in the order a raster axis steps through them
	typedef enum logic [1:0] {
		ST_DISPLAY = 2'd0,
		ST_FRONT   = 2'd1,
		ST_PULSE   = 2'd2,
		ST_BACK    = 2'd3
	} raster_state_e;

	// Implemented subset of the 6845 register file
	typedef struct packed {
		logic [7:0]  horz_display;
		logic [6:0]  vert_display;
		logic [4:0]  max_scanline;
		logic [4:0]  cursor_start_row;
		logic [4:0]  cursor_end_row;
		logic [1:0]  cursor_blink_mode;
		logic [1:0]  interlace_mode;
		logic [13:0] start_adr;
		logic [13:0] cursor_adr;
	} crtc_regs_t;

	typedef struct packed {
		logic       cursor_seg0;
		logic       cursor_seg1;
		logic       cursor_seg23;
		logic       fast_clock;
		logic [1:0] shift_rate;
		logic       unused;
		logic       flash;
	} ula_control_t;

	typedef struct packed {
		logic [3:0] index;
		logic [3:0] colour;
	} ula_palette_w_t;

	// One ULA data byte, meaning picked by a0
	typedef union packed {
		ula_control_t   control;
		ula_palette_w_t palette;
	} ula_write_u;

	typedef struct packed {
		logic       cs_crtc;
		logic       cs_ula;
		logic       rnw;
		logic       a0;
		logic       strobe;
		logic [7:0] wdata;
	} host_bus_t;

	typedef struct packed {
		logic new_line;
		logic new_screen;
		logic host_disen;
	} raster_marks_t;

endpackage

`default_nettype wire
